// File: verilog.f
+incdir+tb
rtl/cam_pkg.sv
rtl/cam_line_if.sv
rtl/dvp_sync_capture.sv
rtl/rgb565_assembler.sv
rtl/grid_pattern_gen.sv
rtl/cam_ctrl.sv
rtl/cam_capture_top.sv
tb/tb_cam_capture.sv

// File: Bender.yml
package:
  name: cam_capture

sources:
  - rtl/cam_pkg.sv
  - rtl/cam_line_if.sv
  - rtl/dvp_sync_capture.sv
  - rtl/rgb565_assembler.sv
  - rtl/grid_pattern_gen.sv
  - rtl/cam_ctrl.sv
  - rtl/cam_capture_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_cam_capture.sv

// File: tb/tb_cam_ref.svh
//////////////////////////////
// reference model of the capture path, included inside the testbench module
// rgb565 widened by zero padding, grid from pair and line index
//////////////////////////////

`ifndef TB_CAM_REF_SVH
`define TB_CAM_REF_SVH

localparam logic [31:0] LFSR_SEED = 32'hb2431dfc;

// expected output pixel of one byte pair
function automatic logic [23:0] exp_pixel(
	input logic       grid,
	input logic [7:0] hi,
	input logic [7:0] lo,
	input int         pair_idx,
	input int         line_idx,
	input logic [2:0] shift
);
	logic [15:0] w;
	logic        h_bit;
	logic        v_bit;
	w     = {hi, lo};           // high byte comes first on the bus
	h_bit = pair_idx[shift];
	v_bit = line_idx[shift];
	if (grid)
		return (h_bit == v_bit) ? 24'hffffff : 24'h000000;
	else
		return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
endfunction

// size register, lines in [27:16], pairs per line in [11:0]
function automatic logic [31:0] exp_size(input int nl, input int np);
	return {4'h0, nl[11:0], 4'h0, np[11:0]};
endfunction

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb}; // new bit lands in bit 0
endfunction

`endif

// File: tb/tb_cam_capture.sv
//////////////////////////////
// drives dvp frames and apb accesses on the pixel clock
// expected pixels are queued only for frames the model sees as enabled
//////////////////////////////

`timescale 1ns/1ns

module tb_cam_capture;
	// watchdog budget of frames x lines x cycles per line
	localparam int WD_FRAMES   = 140;
	localparam int WD_LINES    = 8;
	localparam int WD_LINE_CYC = 40;
	localparam int WD_NS       = WD_FRAMES * WD_LINES * WD_LINE_CYC * 10 + 50000;

	logic        cmos_pclk;
	logic        rst_n;
	logic        cmos_href;
	logic        cmos_vsync;
	logic [7:0]  cmos_data;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pslverr;
	logic        vs;
	logic        hs;
	logic        pix_valid;
	logic [23:0] rgb;

	`include "tb_cam_ref.svh"

	logic [31:0] lfsr_state = LFSR_SEED;
	logic [23:0] exp_q[$];    // expected pixels in order
	string       cur_test = "none";
	int          val_errs = 0;
	int          misc_errs = 0;
	int          n_checks = 0;
	int          n_pushed = 0;
	int          n_got = 0;
	int          n_frames = 0;
	logic        quiet_chk = 1'b0; // video must stay idle
	logic        quiet_seen = 1'b0;
	// dut model
	logic [31:0] ctrl_m = 32'h0;
	logic [6:0]  wait_m = 7'd15;
	logic [6:0]  fcnt_m = 7'd0;
	logic        oen_m = 1'b0;

	cam_capture_top #(.H_CNT_W(12), .V_CNT_W(12)) cam_capture_top_i (
		.cmos_pclk_i  (cmos_pclk),
		.rst_n_i      (rst_n),
		.cmos_href_i  (cmos_href),
		.cmos_vsync_i (cmos_vsync),
		.cmos_data_i  (cmos_data),
		.paddr_i      (paddr),
		.psel_i       (psel),
		.penable_i    (penable),
		.pwrite_i     (pwrite),
		.pwdata_i     (pwdata),
		.prdata_o     (prdata),
		.pslverr_o    (pslverr),
		.vs_o         (vs),
		.hs_o         (hs),
		.pix_valid_o  (pix_valid),
		.rgb_o        (rgb)
	);

	initial
	begin
		cmos_pclk = 1'b0;
		forever #5 cmos_pclk = ~cmos_pclk;
	end

	// one random byte with one lfsr step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		val_errs++;
		$display("ERROR %s/%s expected %h actual %h", cur_test, name, exp, got);
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(posedge cmos_pclk);
		paddr   <= addr;
		pwdata  <= data;
		pwrite  <= 1'b1;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge cmos_pclk);
		penable <= 1'b1; // access phase so the write lands on the next edge
		@(negedge cmos_pclk);
		err = pslverr;
		@(posedge cmos_pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge cmos_pclk);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge cmos_pclk);
		penable <= 1'b1;
		@(negedge cmos_pclk);
		data = prdata; // combinational read data is stable mid cycle
		err  = pslverr;
		@(posedge cmos_pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [3:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_read(addr, rd, err);
		n_checks++;
		if (rd !== exp)
			report_mismatch(name, exp, rd);
		if (err)
		begin
			misc_errs++;
			$display("pslverr raised on a read of mapped register %s", name);
		end
	endtask

	// ctrl write plus model update
	// clearing enable drops out_en at once
	task automatic set_ctrl(input logic [31:0] v);
		logic err;
		apb_write(cam_pkg::ADDR_CTRL, v, err);
		ctrl_m = v;
		if (!v[0])
			oen_m = 1'b0;
	endtask

	task automatic drive_bus(input logic v, input logic h, input logic [7:0] d);
		@(posedge cmos_pclk);
		cmos_vsync <= v;
		cmos_href  <= h;
		cmos_data  <= d;
	endtask

	// one frame where odd lines get a trailing byte when odd is set
	task automatic drive_frame(input int nl, input int np, input bit odd,
		input int dis_line, input int en_line);
		logic [7:0] hi;
		logic [7:0] lo;
		logic       grid;
		logic [2:0] shift;
		drive_bus(1'b0, 1'b0, 8'h00); // vsync falls for the frame start
		n_frames++;
		if (ctrl_m[0] && fcnt_m >= wait_m)
			oen_m = 1'b1;
		if (fcnt_m != 7'd127)
			fcnt_m++;
		grid  = ctrl_m[1];
		shift = ctrl_m[4:2];
		repeat (4) drive_bus(1'b0, 1'b0, 8'h00);
		for (int l = 0; l < nl; l++)
		begin
			for (int p = 0; p < np; p++)
			begin
				hi = rand_byte();
				lo = rand_byte();
				drive_bus(1'b0, 1'b1, hi);
				drive_bus(1'b0, 1'b1, lo);
				if (oen_m)
				begin
					exp_q.push_back(exp_pixel(grid, hi, lo, p, l, shift));
					n_pushed++;
				end
			end
			if (odd && l % 2 == 1)
				drive_bus(1'b0, 1'b1, rand_byte()); // dropped by the dut
			repeat (6) drive_bus(1'b0, 1'b0, 8'h00); // line gap drains the pipe
			if (l == dis_line)
				set_ctrl(ctrl_m & ~32'h1);
			if (l == en_line)
				set_ctrl(ctrl_m | 32'h1);
		end
		repeat (7) drive_bus(1'b1, 1'b0, 8'h00); // vsync high ends the frame
	endtask

	// pixel comparator
	always @(negedge cmos_pclk)
	begin : compare_pix
		logic [23:0] want;
		if (rst_n && pix_valid)
		begin
			n_got++;
			n_checks++;
			if ({hs, vs} !== 2'b10)
				report_mismatch($sformatf("sync at pixel %0d", n_got), 32'b10, {hs, vs});
			if (exp_q.size() == 0)
			begin
				misc_errs++;
				$display("%s: pixel %0d came out with no pixel expected", cur_test, n_got);
			end
			else
			begin
				want = exp_q.pop_front();
				if (rgb !== want)
					report_mismatch($sformatf("pixel %0d", n_got), want, rgb);
			end
		end
	end

	// video must stay idle while waiting for frames
	always @(negedge cmos_pclk)
	begin
		if (quiet_chk && !quiet_seen && (pix_valid || hs || vs))
		begin
			misc_errs++;
			quiet_seen = 1'b1;
			$display("video outputs went active during the frame wait");
		end
	end

	initial
	begin
		#(WD_NS);
		$display("watchdog expired before the tests completed");
		$display("TB FAILED");
		$finish;
	end

	initial
	begin : main
		logic [31:0] rd;
		logic        err;
		cmos_href  = 1'b0;
		cmos_vsync = 1'b1; // idle bus is between frames
		cmos_data  = 8'h00;
		paddr      = 4'h0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = 32'h0;
		rst_n      = 1'b0;
		repeat (5) @(posedge cmos_pclk);
		rst_n <= 1'b1;

		cur_test = "reset_regs";
		check_reg("ctrl_reset", cam_pkg::ADDR_CTRL, 32'h0);
		check_reg("wait_reset", cam_pkg::ADDR_WAIT, 32'd15);
		check_reg("status_reset", cam_pkg::ADDR_STATUS, 32'h0);
		set_ctrl(32'h1e); // grid with shift 7 and disabled
		check_reg("ctrl_readback", cam_pkg::ADDR_CTRL, 32'h1e);
		apb_write(cam_pkg::ADDR_WAIT, 32'h55, err);
		check_reg("wait_readback", cam_pkg::ADDR_WAIT, 32'h55);
		apb_read(4'h2, rd, err);
		if (!err)
		begin
			misc_errs++;
			$display("read of unmapped offset 0x2 gave no pslverr");
		end
		apb_write(4'h6, 32'hffffffff, err);
		if (!err)
		begin
			misc_errs++;
			$display("write to unmapped offset 0x6 gave no pslverr");
		end

		cur_test = "frame_wait";
		apb_write(cam_pkg::ADDR_WAIT, 32'd3, err);
		wait_m = 7'd3;
		set_ctrl(32'h1);
		quiet_chk = 1'b1;
		repeat (3) drive_frame(4, 4, 1'b0, -1, -1);
		check_reg("status_waiting", cam_pkg::ADDR_STATUS, 32'h03);
		quiet_chk = 1'b0;
		drive_frame(4, 4, 1'b0, -1, -1);
		@(negedge cmos_pclk);
		n_checks++;
		if ({hs, vs} !== 2'b01)
			report_mismatch("sync_between_frames", 32'b01, {hs, vs});
		check_reg("status_running", cam_pkg::ADDR_STATUS, 32'h84);

		cur_test = "sensor";
		drive_frame(3, 7, 1'b1, -1, -1);
		drive_frame(2, 5, 1'b1, -1, -1);

		cur_test = "grid_shift0";
		set_ctrl(32'h3);
		drive_frame(4, 4, 1'b0, -1, -1);
		cur_test = "grid_shift2";
		set_ctrl(32'hb);
		drive_frame(8, 8, 1'b0, -1, -1);

		cur_test = "frame_size";
		set_ctrl(32'h1);
		drive_frame(5, 6, 1'b1, -1, -1);
		check_reg("size", cam_pkg::ADDR_SIZE, exp_size(5, 6));

		cur_test = "disable";
		drive_frame(4, 4, 1'b0, 1, 2); // off after line 1 and on again after line 2
		check_reg("status_disabled", cam_pkg::ADDR_STATUS, {24'h0, 1'b0, fcnt_m});
		drive_frame(2, 3, 1'b0, -1, -1);
		check_reg("status_resumed", cam_pkg::ADDR_STATUS, {24'h0, 1'b1, fcnt_m});

		cur_test = "frame_count";
		while (n_frames < 130)
			drive_frame(1, 1, 1'b0, -1, -1);
		check_reg("status_saturated", cam_pkg::ADDR_STATUS, 32'hff);

		cur_test = "drain";
		while (exp_q.size() != 0)
			@(posedge cmos_pclk);
		repeat (8) @(posedge cmos_pclk); // room for a stray pixel
		n_checks++;
		if (n_got != n_pushed)
			report_mismatch("pixel_count", n_pushed, n_got);

		$display("checks %0d, value errors %0d, other errors %0d, frames %0d, pixels %0d",
			n_checks, val_errs, misc_errs, n_frames, n_got);
		if (val_errs == 0 && misc_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: rtl/cam_capture_top.sv
//////////////////////////////
// single clock, apb runs on the sensor pixel clock
// counter widths must cover the largest line and frame
//////////////////////////////

`timescale 1ns/1ns

module cam_capture_top #(
	parameter int H_CNT_W = 12,
	parameter int V_CNT_W = 12
) (
	input  logic                        cmos_pclk_i,
	input  logic                        rst_n_i,
	input  logic                        cmos_href_i,
	input  logic                        cmos_vsync_i,
	input  logic [7:0]                  cmos_data_i,
	input  logic [cam_pkg::ADDR_W-1:0]  paddr_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic                        pwrite_i,
	input  logic [31:0]                 pwdata_i,
	output logic [31:0]                 prdata_o,
	output logic                        pslverr_o,
	output logic                        vs_o,
	output logic                        hs_o,
	output logic                        pix_valid_o,
	output logic [cam_pkg::RGB_W-1:0]   rgb_o
);
	logic                              sensor_valid;
	logic [cam_pkg::RGB_W-1:0]         sensor_rgb;
	logic                              grid_valid;
	logic [cam_pkg::RGB_W-1:0]         grid_rgb;
	logic [cam_pkg::CTRL_SHIFT_W-1:0]  grid_shift;

	cam_line_if #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) line_if ();

	// bus register, edges, counters
	dvp_sync_capture #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) dvp_sync_capture_i (
		.cmos_pclk_i  (cmos_pclk_i),
		.rst_n_i      (rst_n_i),
		.cmos_href_i  (cmos_href_i),
		.cmos_vsync_i (cmos_vsync_i),
		.cmos_data_i  (cmos_data_i),
		.line         (line_if)
	);

	rgb565_assembler rgb565_assembler_i (
		.cmos_pclk_i    (cmos_pclk_i),
		.rst_n_i        (rst_n_i),
		.line           (line_if),
		.sensor_valid_o (sensor_valid),
		.sensor_rgb_o   (sensor_rgb)
	);

	grid_pattern_gen #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) grid_pattern_gen_i (
		.cmos_pclk_i  (cmos_pclk_i),
		.rst_n_i      (rst_n_i),
		.line         (line_if),
		.grid_shift_i (grid_shift),
		.grid_valid_o (grid_valid),
		.grid_rgb_o   (grid_rgb)
	);

	// registers, frame wait, source select
	cam_ctrl #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) cam_ctrl_i (
		.cmos_pclk_i    (cmos_pclk_i),
		.rst_n_i        (rst_n_i),
		.paddr_i        (paddr_i),
		.psel_i         (psel_i),
		.penable_i      (penable_i),
		.pwrite_i       (pwrite_i),
		.pwdata_i       (pwdata_i),
		.prdata_o       (prdata_o),
		.pslverr_o      (pslverr_o),
		.line           (line_if),
		.sensor_valid_i (sensor_valid),
		.sensor_rgb_i   (sensor_rgb),
		.grid_valid_i   (grid_valid),
		.grid_rgb_i     (grid_rgb),
		.grid_shift_o   (grid_shift),
		.vs_o           (vs_o),
		.hs_o           (hs_o),
		.pix_valid_o    (pix_valid_o),
		.rgb_o          (rgb_o)
	);

endmodule

// File: rtl/cam_ctrl.sv
//////////////////////////////
// zero wait apb in the pixel clock domain, no pready
// output starts only at a frame start, no back-pressure
//////////////////////////////

`timescale 1ns/1ns

module cam_ctrl #(
	parameter int H_CNT_W = 12,
	parameter int V_CNT_W = 12
) (
	input  logic                              cmos_pclk_i,
	input  logic                              rst_n_i,
	input  logic [cam_pkg::ADDR_W-1:0]        paddr_i,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [31:0]                       pwdata_i,
	output logic [31:0]                       prdata_o,
	output logic                              pslverr_o,
	cam_line_if.dst                           line,
	input  logic                              sensor_valid_i,
	input  logic [cam_pkg::RGB_W-1:0]         sensor_rgb_i,
	input  logic                              grid_valid_i,
	input  logic [cam_pkg::RGB_W-1:0]         grid_rgb_i,
	output logic [cam_pkg::CTRL_SHIFT_W-1:0]  grid_shift_o,
	output logic                              vs_o,
	output logic                              hs_o,
	output logic                              pix_valid_o,
	output logic [cam_pkg::RGB_W-1:0]         rgb_o
);
	localparam int SZ_W = cam_pkg::SIZE_FLD_W;

	logic                              enable_r;
	logic                              pattern_sel_r;
	logic [cam_pkg::CTRL_SHIFT_W-1:0]  grid_shift_r;
	logic [cam_pkg::FRAME_CNT_W-1:0]   wait_r;
	logic [cam_pkg::FRAME_CNT_W-1:0]   frame_cnt;
	logic                              out_en;     // frame-wait fsm, 0 wait, 1 run
	logic                              apb_acc;    // access phase
	logic [31:0]                       rd_word;
	logic                              addr_hit;
	logic                              href_q;     // href at pixel stage timing
	logic                              in_frame;   // between frame start and end
	logic [H_CNT_W-1:0]                line_pairs; // pairs of the line just ended
	logic [SZ_W-1:0]                   size_pairs;
	logic [SZ_W-1:0]                   size_lines;
	logic                              sel_valid;
	logic [cam_pkg::RGB_W-1:0]         sel_rgb;

	assign apb_acc = psel_i & penable_i;

	// ctrl and wait registers, written in the access phase
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			enable_r      <= 1'b0;
			pattern_sel_r <= 1'b0;
			grid_shift_r  <= '0;
			wait_r        <= cam_pkg::WAIT_DEFAULT;
		end
		else if (apb_acc && pwrite_i)
		begin
			case (paddr_i)
				cam_pkg::ADDR_CTRL:
				begin
					enable_r      <= pwdata_i[cam_pkg::CTRL_EN_BIT];
					pattern_sel_r <= pwdata_i[cam_pkg::CTRL_PAT_BIT];
					grid_shift_r  <= pwdata_i[cam_pkg::CTRL_SHIFT_LSB +: cam_pkg::CTRL_SHIFT_W];
				end
				cam_pkg::ADDR_WAIT: wait_r <= pwdata_i[cam_pkg::FRAME_CNT_W-1:0];
				default: ; // status and size are read only
			endcase
		end
	end

	// read mux, straight from the registers
	always_comb
	begin
		rd_word  = '0;
		addr_hit = 1'b1;
		case (paddr_i)
			cam_pkg::ADDR_CTRL:
			begin
				rd_word[cam_pkg::CTRL_EN_BIT]  = enable_r;
				rd_word[cam_pkg::CTRL_PAT_BIT] = pattern_sel_r;
				rd_word[cam_pkg::CTRL_SHIFT_LSB +: cam_pkg::CTRL_SHIFT_W] = grid_shift_r;
			end
			cam_pkg::ADDR_WAIT: rd_word[cam_pkg::FRAME_CNT_W-1:0] = wait_r;
			cam_pkg::ADDR_STATUS:
			begin
				rd_word[cam_pkg::STATUS_OUTEN_BIT]  = out_en;
				rd_word[cam_pkg::FRAME_CNT_W-1:0]   = frame_cnt;
			end
			cam_pkg::ADDR_SIZE:
			begin
				rd_word[SZ_W-1:0]                        = size_pairs;
				rd_word[cam_pkg::SIZE_LINES_LSB +: SZ_W] = size_lines;
			end
			default: addr_hit = 1'b0; // hole in the map
		endcase
	end

	assign prdata_o  = (apb_acc && !pwrite_i) ? rd_word : '0;
	assign pslverr_o = apb_acc & ~addr_hit;

	// frame counter and output enable
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			frame_cnt <= '0;
			out_en    <= 1'b0;
		end
		else
		begin
			if (line.frame_start && frame_cnt != '1)
				frame_cnt <= frame_cnt + 1'b1; // sticks at 127
			if (!enable_r)
				out_en <= 1'b0; // drops mid frame
			else if (line.frame_start && frame_cnt >= wait_r)
				out_en <= 1'b1; // only on a frame boundary
		end
	end

	// frame level and line delay for vs_o and hs_o
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			in_frame <= 1'b0;
			href_q   <= 1'b0;
		end
		else
		begin
			href_q <= line.href_r;
			if (line.frame_start)
				in_frame <= 1'b1;
			else if (line.frame_end)
				in_frame <= 1'b0;
		end
	end

	// pair count of each line, hcount still holds it as href falls
	always_ff @(posedge cmos_pclk_i)
	begin
		if (href_q && !line.href_r)
			line_pairs <= line.hcount;
	end

	// size latched at frame end
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			size_pairs <= '0;
			size_lines <= '0;
		end
		else if (line.frame_end)
		begin
			size_pairs <= SZ_W'(line_pairs);
			size_lines <= SZ_W'(line.vcount + 1'b1); // index to count
		end
	end

	// source select, both paths have the same latency
	assign sel_valid    = pattern_sel_r ? grid_valid_i : sensor_valid_i;
	assign sel_rgb      = pattern_sel_r ? grid_rgb_i : sensor_rgb_i;
	assign grid_shift_o = grid_shift_r;

	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pix_valid_o <= 1'b0;
			hs_o        <= 1'b0;
			vs_o        <= 1'b0;
		end
		else
		begin
			pix_valid_o <= out_en & sel_valid;
			hs_o        <= out_en & href_q;
			vs_o        <= out_en & ~in_frame; // vsync style, high between frames
		end
	end

	always_ff @(posedge cmos_pclk_i)
	begin
		if (sel_valid)
			rgb_o <= sel_rgb;
	end

endmodule

// File: rtl/grid_pattern_gen.sv
//////////////////////////////
// cell size is 2**grid_shift pairs by 2**grid_shift lines
//////////////////////////////

`timescale 1ns/1ns

module grid_pattern_gen #(
	parameter int H_CNT_W = 12,
	parameter int V_CNT_W = 12
) (
	input  logic                              cmos_pclk_i,
	input  logic                              rst_n_i,
	cam_line_if.dst                           line,
	input  logic [cam_pkg::CTRL_SHIFT_W-1:0]  grid_shift_i,
	output logic                              grid_valid_o,
	output logic [cam_pkg::RGB_W-1:0]         grid_rgb_o
);
	logic [H_CNT_W-1:0] h_idx;
	logic [V_CNT_W-1:0] v_idx;
	logic               cell_white; // same parity of cell column and row

	assign h_idx      = line.hcount;
	assign v_idx      = line.vcount;
	assign cell_white = (h_idx[grid_shift_i] == v_idx[grid_shift_i]);

	// valid mirrors the sensor path latency
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			grid_valid_o <= 1'b0;
		else
			grid_valid_o <= line.pair_stb;
	end

	always_ff @(posedge cmos_pclk_i)
	begin
		if (line.pair_stb)
			grid_rgb_o <= cell_white ? '1 : '0; // white or black
	end

endmodule

// File: rtl/rgb565_assembler.sv
//////////////////////////////
// high byte first on the bus, pairs never span two lines
// rgb888 is zero padded, no bit replication
//////////////////////////////

`timescale 1ns/1ns

module rgb565_assembler (
	input  logic                         cmos_pclk_i,
	input  logic                         rst_n_i,
	cam_line_if.dst                      line,
	output logic                         sensor_valid_o,
	output logic [cam_pkg::RGB_W-1:0]    sensor_rgb_o
);
	logic [7:0]        first_byte; // high byte of the current pair
	cam_pkg::cam_pix_u pix;        // pair as written, read back as rgb565
	logic [7:0]        red8;
	logic [7:0]        grn8;
	logic [7:0]        blu8;

	// hold the first byte, second one arrives with pair_stb
	always_ff @(posedge cmos_pclk_i)
	begin
		if (line.href_r && !line.pair_stb)
			first_byte <= line.byte_r;
	end

	// byte view of the pixel word
	always_comb
	begin
		pix.bytes.hi = first_byte;
		pix.bytes.lo = line.byte_r; // low byte straight from the sync stage
	end

	// rgb view, widened to 8 bits per channel
	// red and blue get 3 zero lsbs
	// green gets 2
	assign red8 = {pix.rgb.r, 3'b000};
	assign grn8 = {pix.rgb.g, 2'b00};
	assign blu8 = {pix.rgb.b, 3'b000};

	// valid strobe, one cycle after pair_stb
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			sensor_valid_o <= 1'b0;
		else
			sensor_valid_o <= line.pair_stb;
	end

	// pixel payload, loaded only on a complete pair
	always_ff @(posedge cmos_pclk_i)
	begin
		if (line.pair_stb)
			sensor_rgb_o <= {red8, grn8, blu8};
	end

endmodule

// File: rtl/dvp_sync_capture.sv
//////////////////////////////
// vsync high between frames, href high while bytes are valid
// an odd trailing byte in a line never raises pair_stb
//////////////////////////////

`timescale 1ns/1ns

module dvp_sync_capture #(
	parameter int H_CNT_W = 12,
	parameter int V_CNT_W = 12
) (
	input  logic       cmos_pclk_i,
	input  logic       rst_n_i,
	input  logic       cmos_href_i,
	input  logic       cmos_vsync_i,
	input  logic [7:0] cmos_data_i,
	cam_line_if.src    line
);
	logic [7:0]         data_r;     // input byte register
	logic [1:0]         vs_hist;    // [0] input register, [1] one cycle older
	logic [1:0]         hr_hist;
	logic               fs_q;       // frame start strobe
	logic               fe_q;       // frame end strobe
	logic               byte_tgl;   // high while second byte is in data_r
	logic               pair_stb_w;
	logic               line_start; // href rising, first byte present
	logic               line_seen;  // first line of the frame started
	logic [H_CNT_W-1:0] hcnt;
	logic [V_CNT_W-1:0] vcnt;

	// sensor byte is payload
	always_ff @(posedge cmos_pclk_i)
	begin
		data_r <= cmos_data_i;
	end

	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			vs_hist <= 2'b11; // idle bus is between frames
			hr_hist <= 2'b00;
			fs_q    <= 1'b0;
			fe_q    <= 1'b0;
		end
		else
		begin
			vs_hist <= {vs_hist[0], cmos_vsync_i};
			hr_hist <= {hr_hist[0], cmos_href_i};
			fs_q    <= vs_hist[1] & ~vs_hist[0]; // falling edge, second stage
			fe_q    <= ~vs_hist[1] & vs_hist[0];
		end
	end

	assign line_start = hr_hist[0] & ~hr_hist[1];
	assign pair_stb_w = hr_hist[0] & byte_tgl;

	// byte toggle and pair counter, both cleared outside href
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			byte_tgl <= 1'b0;
			hcnt     <= '0;
		end
		else if (!hr_hist[0])
		begin
			byte_tgl <= 1'b0;
			hcnt     <= '0;
		end
		else
		begin
			byte_tgl <= ~byte_tgl;
			if (pair_stb_w)
				hcnt <= hcnt + 1'b1; // index of the next pair
		end
	end

	// line counter, first line of a frame stays at 0
	always_ff @(posedge cmos_pclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			vcnt      <= '0;
			line_seen <= 1'b0;
		end
		else if (fs_q)
		begin
			vcnt      <= '0;
			line_seen <= 1'b0;
		end
		else if (line_start)
		begin
			if (line_seen)
				vcnt <= vcnt + 1'b1;
			line_seen <= 1'b1;
		end
	end

	assign line.byte_r      = data_r;
	assign line.href_r      = hr_hist[0];
	assign line.frame_start = fs_q;
	assign line.frame_end   = fe_q;
	assign line.pair_stb    = pair_stb_w;
	assign line.hcount      = hcnt;
	assign line.vcount      = vcnt;

endmodule

// File: rtl/cam_line_if.sv
//////////////////////////////
// sync stage to datapath link, all signals in the pclk domain
// hcount is the pair index, not the byte index
//////////////////////////////

`timescale 1ns/1ns

interface cam_line_if #(
	parameter int H_CNT_W = 12,
	parameter int V_CNT_W = 12
) ();
	logic [7:0]         byte_r;      // registered sensor byte
	logic               href_r;      // registered line valid
	logic               frame_start; // one cycle, vsync fall
	logic               frame_end;   // one cycle, vsync rise
	logic               pair_stb;    // second byte of a pair present
	logic [H_CNT_W-1:0] hcount;      // pair index within line
	logic [V_CNT_W-1:0] vcount;      // line index within frame

	// driven by the sync stage
	modport src (
		output byte_r, href_r, frame_start, frame_end, pair_stb, hcount, vcount
	);

	// datapath and control side
	modport dst (
		input byte_r, href_r, frame_start, frame_end, pair_stb, hcount, vcount
	);

endinterface

// File: rtl/cam_pkg.sv
//////////////////////////////
// shared types and register map of the dvp capture front end
// apb offsets are 4-bit byte offsets, one 32-bit word each
//////////////////////////////

package cam_pkg;

	// apb address width seen by the register file
	localparam int ADDR_W = 4;

	// register offsets
	localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_WAIT   = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h8;
	localparam logic [ADDR_W-1:0] ADDR_SIZE   = 4'hC;

	// ctrl fields
	localparam int CTRL_EN_BIT    = 0; // output enable
	localparam int CTRL_PAT_BIT   = 1; // 0 sensor, 1 grid
	localparam int CTRL_SHIFT_LSB = 2; // grid_shift lsb
	localparam int CTRL_SHIFT_W   = 3; // counter bit index 0..7

	// frame counter and wait
	localparam int FRAME_CNT_W = 7; // saturates at 127
	localparam logic [FRAME_CNT_W-1:0] WAIT_DEFAULT = 7'd15;

	// status fields, frame count sits in the low bits
	localparam int STATUS_OUTEN_BIT = 7;

	// size fields
	localparam int SIZE_FLD_W     = 12; // pairs per line in [11:0]
	localparam int SIZE_LINES_LSB = 16; // lines per frame in [27:16]

	// output pixel width
	localparam int RGB_W = 24;

	// one pixel word, filled as two sensor bytes and read as rgb565 fields
	typedef union packed {
		struct packed {
			logic [7:0] hi; // first byte on the bus
			logic [7:0] lo;
		} bytes;
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
	} cam_pix_u;

endpackage
